/* Bender.yml */
package:
  name: lab4_ctrl

sources:
  # packages first, then the engines, then the top level
  - files:
      - hw/lab4_chip_pkg.sv
      - hw/lab4_bus_pkg.sv
      - hw/lab4_reg_bank.sv
      - hw/lab4_serial_loader.sv
      - hw/lab4_ramp_timer.sv
      - hw/lab4_readout_seq.sv
      - hw/lab4_ctrl_top.sv

  - target: test
    files:
      - test/tb_lab4_ctrl_models.sv
      - test/tb_lab4_ctrl.sv

/* hw/lab4_bus_pkg.sv */
`default_nettype none

package lab4_bus_pkg;

	localparam int BUS_ADR_W = 7;
	localparam int BUS_SEL_W = 4;
	localparam int BUS_DAT_W = 32;

	// wishbone style request, byte addressed
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [BUS_ADR_W-1:0] adr;
		logic [BUS_SEL_W-1:0] sel;
		logic [BUS_DAT_W-1:0] dat;
	} bus_req_t;

	typedef struct packed {
		logic                 ack;
		logic [BUS_DAT_W-1:0] dat;
	} bus_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////////////////////

	localparam logic [BUS_ADR_W-1:0] ADDR_CONTROL        = 7'h00;
	localparam logic [BUS_ADR_W-1:0] ADDR_SHIFT_PRESCALE = 7'h04;
	localparam logic [BUS_ADR_W-1:0] ADDR_RAMP_DELAY     = 7'h0C;
	localparam logic [BUS_ADR_W-1:0] ADDR_WCLK_STOP      = 7'h10;
	localparam logic [BUS_ADR_W-1:0] ADDR_RAMP_CMD       = 7'h14;
	localparam logic [BUS_ADR_W-1:0] ADDR_USER_WRITE     = 7'h18;
	localparam logic [BUS_ADR_W-1:0] ADDR_TRIGGER        = 7'h54;
	localparam logic [BUS_ADR_W-1:0] ADDR_READOUT        = 7'h58;

	localparam logic [7:0]  SHIFT_PRESCALE_DEFAULT = 8'd1;
	localparam logic [15:0] RAMP_DELAY_DEFAULT     = 16'd0;
	localparam logic [15:0] WCLK_STOP_DEFAULT      = 16'd1024;

	// field positions
	localparam int CTRL_RUNMODE_BIT         = 1;
	localparam int CTRL_REGCLR_LSB          = 16;
	localparam int USER_GO_BIT              = 31;   // busy on readback
	localparam int USER_SEL_LSB             = 24;
	localparam int RAMP_START_BIT           = 6;
	localparam int RAMP_PENDING_BIT         = 7;
	localparam int TRIG_FORCE_BIT           = 1;
	localparam int TRIG_COUNT_LSB           = 8;
	localparam int READOUT_NOT_DONE_BIT     = 0;
	localparam int READOUT_FORCE_ACTIVE_BIT = 5;

endpackage

`default_nettype wire

/* hw/lab4_chip_pkg.sv */
`default_nettype none

package lab4_chip_pkg;

	////////////////////////////////////////////////////////////////////////////
	// chip geometry
	////////////////////////////////////////////////////////////////////////////

	// one LAB4 configuration word, shifted MSB first
	localparam int SER_WORD_W = 24;
	// chip select field of the user write register
	localparam int SEL_W = 5;
	localparam int RAMP_CNT_W = 16;
	localparam int READOUT_CNT_W = 8;

	typedef logic [SER_WORD_W-1:0] ser_word_t;

	typedef struct packed {
		logic             go;
		logic [SEL_W-1:0] sel;
		ser_word_t        word;
	} ser_cmd_t;

	// ramp-to-wilkinson delay, then wilkinson stop count
	typedef struct packed {
		logic [RAMP_CNT_W-1:0] delay;
		logic [RAMP_CNT_W-1:0] stop;
	} ramp_cfg_t;

	// count is the number of readouts beyond the first
	typedef struct packed {
		logic                     force_req;
		logic [READOUT_CNT_W-1:0] count;
	} seq_cmd_t;

endpackage

`default_nettype wire

/* hw/lab4_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lab4_ctrl_top #(
	parameter int NUM_LABS   = 4,
	parameter int NUM_REGCLR = 1
) (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  lab4_bus_pkg::bus_req_t bus_req_i,
	output lab4_bus_pkg::bus_rsp_t bus_rsp_o,
	input  logic                   complete_i,
	output logic                   readout_o,
	output logic                   event_done_o,
	output logic                   runmode_o,
	output logic [NUM_REGCLR-1:0]  regclear_o,
	output logic [NUM_LABS-1:0]    sin_o,
	output logic                   sclk_o,
	output logic [NUM_LABS-1:0]    pclk_o,
	output logic                   ramp_o,
	output logic                   wclk_gate_o
);
	lab4_chip_pkg::ser_cmd_t  ser_cmd;
	lab4_chip_pkg::ramp_cfg_t ramp_cfg;
	lab4_chip_pkg::seq_cmd_t  seq_cmd;
	logic [7:0]               shift_prescale;
	logic                     ser_busy;
	logic                     ramp_start;
	logic                     ramp_pending;
	logic                     force_active;
	logic                     readout_not_done;

	lab4_reg_bank #(.NUM_LABS(NUM_LABS), .NUM_REGCLR(NUM_REGCLR)) u_reg_bank (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.bus_req_i(bus_req_i), .bus_rsp_o(bus_rsp_o),
		.ser_cmd_o(ser_cmd), .shift_prescale_o(shift_prescale), .ser_busy_i(ser_busy),
		.ramp_cfg_o(ramp_cfg), .ramp_start_o(ramp_start), .ramp_pending_i(ramp_pending),
		.seq_cmd_o(seq_cmd), .force_active_i(force_active),
		.readout_not_done_i(readout_not_done),
		.runmode_o(runmode_o), .regclear_o(regclear_o)
	);

	lab4_serial_loader #(.NUM_LABS(NUM_LABS)) u_serial_loader (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.ser_cmd_i(ser_cmd), .prescale_i(shift_prescale), .busy_o(ser_busy),
		.sin_o(sin_o), .sclk_o(sclk_o), .pclk_o(pclk_o)
	);

	lab4_ramp_timer u_ramp_timer (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.cfg_i(ramp_cfg), .start_i(ramp_start), .pending_o(ramp_pending),
		.ramp_o(ramp_o), .wclk_gate_o(wclk_gate_o)
	);

	lab4_readout_seq u_readout_seq (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.cmd_i(seq_cmd), .complete_i(complete_i),
		.readout_o(readout_o), .event_done_o(event_done_o),
		.force_active_o(force_active), .readout_not_done_o(readout_not_done)
	);

endmodule

`default_nettype wire

/* hw/lab4_ramp_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module lab4_ramp_timer (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  lab4_chip_pkg::ramp_cfg_t cfg_i,
	input  logic                     start_i,
	output logic                     pending_o,
	output logic                     ramp_o,
	output logic                     wclk_gate_o
);
	import lab4_chip_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DELAY,
		ST_GATE
	} state_t;

	state_t                state_q;
	logic [RAMP_CNT_W-1:0] cnt_q;
	logic [RAMP_CNT_W-1:0] stop_q;

	// cnt_q holds the cycles left in the current phase
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				ST_IDLE: if (start_i) begin
					if (cfg_i.delay != '0) begin
						state_q <= ST_DELAY;
						cnt_q   <= cfg_i.delay;
					end else if (cfg_i.stop != '0) begin
						state_q <= ST_GATE;
						cnt_q   <= cfg_i.stop;
					end
				end
				ST_DELAY: if (cnt_q == RAMP_CNT_W'(1)) begin
					state_q <= (stop_q != '0) ? ST_GATE : ST_IDLE;
					cnt_q   <= stop_q;
				end else begin
					cnt_q <= cnt_q - 1'b1;
				end
				ST_GATE: if (cnt_q == RAMP_CNT_W'(1))
					state_q <= ST_IDLE;
				else
					cnt_q <= cnt_q - 1'b1;
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && start_i)
			stop_q <= cfg_i.stop;
	end

	assign ramp_o      = (state_q != ST_IDLE);
	assign wclk_gate_o = (state_q == ST_GATE);
	assign pending_o   = ramp_o;

endmodule

`default_nettype wire

/* hw/lab4_readout_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module lab4_readout_seq (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  lab4_chip_pkg::seq_cmd_t cmd_i,
	input  logic                    complete_i,
	output logic                    readout_o,
	output logic                    event_done_o,
	output logic                    force_active_o,
	output logic                    readout_not_done_o
);
	import lab4_chip_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT
	} state_t;

	state_t                   state_q;
	logic [READOUT_CNT_W-1:0] count_q;
	logic [READOUT_CNT_W-1:0] done_cnt_q;
	logic                     readout_q;
	logic                     event_done_q;
	logic                     not_done_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q      <= ST_IDLE;
			done_cnt_q   <= '0;
			readout_q    <= 1'b0;
			event_done_q <= 1'b0;
			not_done_q   <= 1'b0;
		end else begin
			readout_q    <= 1'b0;
			event_done_q <= 1'b0;
			case (state_q)
				ST_IDLE: if (cmd_i.force_req) begin
					state_q    <= ST_ISSUE;
					done_cnt_q <= '0;
				end
				ST_ISSUE: begin
					readout_q  <= 1'b1;
					not_done_q <= 1'b1;
					state_q    <= ST_WAIT;
				end
				// held here until the readout side reports back
				ST_WAIT: if (complete_i) begin
					not_done_q   <= 1'b0;
					event_done_q <= 1'b1;
					if (done_cnt_q == count_q) begin
						state_q <= ST_IDLE;
					end else begin
						done_cnt_q <= done_cnt_q + 1'b1;
						state_q    <= ST_ISSUE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && cmd_i.force_req)
			count_q <= cmd_i.count;
	end

	assign readout_o          = readout_q;
	assign event_done_o       = event_done_q;
	assign force_active_o     = (state_q != ST_IDLE);
	assign readout_not_done_o = not_done_q;

endmodule

`default_nettype wire

/* hw/lab4_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module lab4_reg_bank #(
	parameter int NUM_LABS   = 4,
	parameter int NUM_REGCLR = 1
) (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  lab4_bus_pkg::bus_req_t   bus_req_i,
	output lab4_bus_pkg::bus_rsp_t   bus_rsp_o,
	output lab4_chip_pkg::ser_cmd_t  ser_cmd_o,
	output logic [7:0]               shift_prescale_o,
	input  logic                     ser_busy_i,
	output lab4_chip_pkg::ramp_cfg_t ramp_cfg_o,
	output logic                     ramp_start_o,
	input  logic                     ramp_pending_i,
	output lab4_chip_pkg::seq_cmd_t  seq_cmd_o,
	input  logic                     force_active_i,
	input  logic                     readout_not_done_i,
	output logic                     runmode_o,
	output logic [NUM_REGCLR-1:0]    regclear_o
);
	import lab4_bus_pkg::*;
	import lab4_chip_pkg::*;

	logic                     strobe;
	logic                     wr_en;
	logic                     runmode_q;
	logic [NUM_REGCLR-1:0]    regclear_q;
	logic [7:0]               prescale_q;
	logic [RAMP_CNT_W-1:0]    ramp_delay_q;
	logic [RAMP_CNT_W-1:0]    wclk_stop_q;
	ser_word_t                user_word_q;
	logic [SEL_W-1:0]         user_sel_q;
	logic                     user_go_q;
	logic                     ramp_start_q;
	logic                     force_q;
	logic [READOUT_CNT_W-1:0] force_count_q;
	logic                     ack_q;
	logic [BUS_DAT_W-1:0]     rdata_d;
	logic [BUS_DAT_W-1:0]     rdata_q;

	assign strobe = bus_req_i.cyc && bus_req_i.stb;
	assign wr_en  = strobe && bus_req_i.we;

	////////////////////////////////////////////////////////////////////////////
	// write decode
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			runmode_q     <= 1'b0;
			regclear_q    <= '0;
			prescale_q    <= SHIFT_PRESCALE_DEFAULT;
			ramp_delay_q  <= RAMP_DELAY_DEFAULT;
			wclk_stop_q   <= WCLK_STOP_DEFAULT;
			user_word_q   <= '0;
			user_sel_q    <= '0;
			user_go_q     <= 1'b0;
			ramp_start_q  <= 1'b0;
			force_q       <= 1'b0;
			force_count_q <= '0;
			ack_q         <= 1'b0;
		end else begin
			// command bits only pulse
			user_go_q    <= 1'b0;
			ramp_start_q <= 1'b0;
			force_q      <= 1'b0;
			ack_q        <= strobe;
			if (wr_en) begin
				case (bus_req_i.adr)
					ADDR_CONTROL: begin
						runmode_q  <= bus_req_i.dat[CTRL_RUNMODE_BIT];
						regclear_q <= bus_req_i.dat[CTRL_REGCLR_LSB +: NUM_REGCLR];
					end
					ADDR_SHIFT_PRESCALE: prescale_q   <= bus_req_i.dat[7:0];
					ADDR_RAMP_DELAY:     ramp_delay_q <= bus_req_i.dat[RAMP_CNT_W-1:0];
					ADDR_WCLK_STOP:      wclk_stop_q  <= bus_req_i.dat[RAMP_CNT_W-1:0];
					ADDR_RAMP_CMD:       ramp_start_q <= bus_req_i.dat[RAMP_START_BIT];
					ADDR_USER_WRITE: begin
						user_word_q <= bus_req_i.dat[SER_WORD_W-1:0];
						user_sel_q  <= bus_req_i.dat[USER_SEL_LSB +: SEL_W];
						user_go_q   <= bus_req_i.dat[USER_GO_BIT];
					end
					ADDR_TRIGGER: begin
						// byte lanes are independent here
						if (bus_req_i.sel[0])
							force_q <= bus_req_i.dat[TRIG_FORCE_BIT];
						if (bus_req_i.sel[1])
							force_count_q <= bus_req_i.dat[TRIG_COUNT_LSB +: READOUT_CNT_W];
					end
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// readback
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rdata_d = '0;
		case (bus_req_i.adr)
			ADDR_CONTROL: begin
				rdata_d[CTRL_RUNMODE_BIT]                 = runmode_q;
				rdata_d[CTRL_REGCLR_LSB +: NUM_REGCLR]    = regclear_q;
			end
			ADDR_SHIFT_PRESCALE: rdata_d[7:0]            = prescale_q;
			ADDR_RAMP_DELAY:     rdata_d[RAMP_CNT_W-1:0] = ramp_delay_q;
			ADDR_WCLK_STOP:      rdata_d[RAMP_CNT_W-1:0] = wclk_stop_q;
			ADDR_RAMP_CMD:       rdata_d[RAMP_PENDING_BIT] = ramp_pending_i;
			ADDR_USER_WRITE: begin
				rdata_d[USER_GO_BIT]            = ser_busy_i;
				rdata_d[USER_SEL_LSB +: SEL_W] = user_sel_q;
				rdata_d[SER_WORD_W-1:0]         = user_word_q;
			end
			ADDR_TRIGGER: rdata_d[TRIG_COUNT_LSB +: READOUT_CNT_W] = force_count_q;
			ADDR_READOUT: begin
				rdata_d[READOUT_FORCE_ACTIVE_BIT] = force_active_i;
				rdata_d[READOUT_NOT_DONE_BIT]     = readout_not_done_i;
			end
			default: ;
		endcase
	end

	// sampled on the strobe, presented with ack
	always_ff @(posedge clk_i) begin
		if (strobe)
			rdata_q <= rdata_d;
	end

	assign bus_rsp_o        = '{ack: ack_q, dat: rdata_q};
	assign ser_cmd_o        = '{go: user_go_q, sel: user_sel_q, word: user_word_q};
	assign shift_prescale_o = prescale_q;
	assign ramp_cfg_o       = '{delay: ramp_delay_q, stop: wclk_stop_q};
	assign ramp_start_o     = ramp_start_q;
	assign seq_cmd_o        = '{force_req: force_q, count: force_count_q};
	assign runmode_o        = runmode_q;
	assign regclear_o       = regclear_q;

endmodule

`default_nettype wire

/* hw/lab4_serial_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module lab4_serial_loader #(
	parameter int NUM_LABS = 4
) (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  lab4_chip_pkg::ser_cmd_t ser_cmd_i,
	input  logic [7:0]              prescale_i,
	output logic                    busy_o,
	output logic [NUM_LABS-1:0]     sin_o,
	output logic                    sclk_o,
	output logic [NUM_LABS-1:0]     pclk_o
);
	import lab4_chip_pkg::*;

	localparam int BIT_CNT_W = $clog2(SER_WORD_W);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_LATCH
	} state_t;

	state_t               state_q;
	logic [7:0]           pre_cnt_q;
	logic [7:0]           pre_max_q;
	logic                 half_q;
	logic [BIT_CNT_W-1:0] bit_cnt_q;
	ser_word_t            shreg_q;
	logic [SEL_W-1:0]     sel_q;
	logic                 pre_wrap;

	// one phase is prescale+1 clocks
	assign pre_wrap = (pre_cnt_q == pre_max_q);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q   <= ST_IDLE;
			pre_cnt_q <= '0;
			half_q    <= 1'b0;
			bit_cnt_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: if (ser_cmd_i.go) begin
					state_q   <= ST_SHIFT;
					pre_cnt_q <= '0;
					half_q    <= 1'b0;
					bit_cnt_q <= '0;
				end
				ST_SHIFT: if (pre_wrap) begin
					pre_cnt_q <= '0;
					half_q    <= ~half_q;
					// sclk falls: move on to the next bit
					if (half_q) begin
						if (bit_cnt_q == BIT_CNT_W'(SER_WORD_W - 1))
							state_q <= ST_LATCH;
						else
							bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end else begin
					pre_cnt_q <= pre_cnt_q + 1'b1;
				end
				ST_LATCH: if (pre_wrap) begin
					state_q   <= ST_IDLE;
					pre_cnt_q <= '0;
				end else begin
					pre_cnt_q <= pre_cnt_q + 1'b1;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// word, target and pace are frozen for the whole load
	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && ser_cmd_i.go) begin
			shreg_q   <= ser_cmd_i.word;
			sel_q     <= ser_cmd_i.sel;
			pre_max_q <= prescale_i;
		end else if (state_q == ST_SHIFT && pre_wrap && half_q) begin
			shreg_q <= shreg_q << 1;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LABS; i++) begin
			sin_o[i]  = (state_q == ST_SHIFT) && (sel_q == SEL_W'(i)) && shreg_q[SER_WORD_W-1];
			pclk_o[i] = (state_q == ST_LATCH) && (sel_q == SEL_W'(i));
		end
	end

	assign sclk_o = (state_q == ST_SHIFT) && half_q;
	assign busy_o = (state_q != ST_IDLE);

endmodule

`default_nettype wire

/* lab4_ctrl.f */
hw/lab4_chip_pkg.sv
hw/lab4_bus_pkg.sv
hw/lab4_reg_bank.sv
hw/lab4_serial_loader.sv
hw/lab4_ramp_timer.sv
hw/lab4_readout_seq.sv
hw/lab4_ctrl_top.sv
test/tb_lab4_ctrl_models.sv
test/tb_lab4_ctrl.sv

/* test/tb_lab4_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lab4_ctrl;
	import lab4_bus_pkg::*;

	localparam int NUM_LABS    = 4;
	localparam int NUM_REGCLR  = 1;
	localparam int BUS_TIMEOUT = 8;
	localparam int POLL_MAX    = 400;
	localparam int DRAIN_MAX   = 4;

	logic                  clk = 1'b0;
	logic                  rst_n;
	bus_req_t              bus_req;
	bus_rsp_t              bus_rsp;
	logic                  complete;
	logic                  readout;
	logic                  event_done;
	logic                  runmode;
	logic [NUM_REGCLR-1:0] regclear;
	logic [NUM_LABS-1:0]   sin;
	logic                  sclk;
	logic [NUM_LABS-1:0]   pclk;
	logic                  ramp;
	logic                  wclk_gate;

	logic                  mon_clear;
	logic [23:0]           mon_word;
	int                    mon_bits;
	logic [NUM_LABS-1:0]   mon_sin_seen;
	logic [NUM_LABS-1:0]   mon_pclk_seen;
	int                    mon_pclk_cycles;
	int                    mon_ramp_cycles;
	int                    mon_gate_cycles;
	int                    mon_readouts;
	int                    mon_events;
	logic                  resp_en;
	logic [3:0]            resp_delay;

	logic [31:0]           lfsr_q = 32'h647a93ca;
	int                    err_count;

	// register contents as the bus master has written them
	logic                  sh_runmode;
	logic                  sh_regclr;
	logic [7:0]            sh_prescale;
	logic [15:0]           sh_delay;
	logic [15:0]           sh_stop;
	logic [4:0]            sh_sel;
	logic [23:0]           sh_word;
	logic [7:0]            sh_count;

	// results waiting for the compare process
	string                 name_q[$];
	logic [31:0]           exp_q[$];
	logic [31:0]           act_q[$];
	string                 cmp_name;
	logic [31:0]           cmp_exp;
	logic [31:0]           cmp_act;

	// 0x08 and 0x40 are unmapped
	logic [BUS_ADR_W-1:0]  reg_addrs[10] = '{ADDR_CONTROL, ADDR_SHIFT_PRESCALE, 7'h08,
		ADDR_RAMP_DELAY, ADDR_WCLK_STOP, ADDR_RAMP_CMD, ADDR_USER_WRITE, ADDR_TRIGGER,
		ADDR_READOUT, 7'h40};

	always #50 clk = ~clk;

	lab4_ctrl_top #(.NUM_LABS(NUM_LABS), .NUM_REGCLR(NUM_REGCLR)) u_lab4_ctrl_top (
		.clk_i(clk), .rst_n_i(rst_n),
		.bus_req_i(bus_req), .bus_rsp_o(bus_rsp),
		.complete_i(complete), .readout_o(readout), .event_done_o(event_done),
		.runmode_o(runmode), .regclear_o(regclear),
		.sin_o(sin), .sclk_o(sclk), .pclk_o(pclk),
		.ramp_o(ramp), .wclk_gate_o(wclk_gate)
	);

	pin_monitor #(.NUM_LABS(NUM_LABS)) u_pin_monitor (
		.clk_i(clk), .clear_i(mon_clear),
		.sin_i(sin), .sclk_i(sclk), .pclk_i(pclk),
		.ramp_i(ramp), .wclk_gate_i(wclk_gate),
		.readout_i(readout), .event_done_i(event_done),
		.word_o(mon_word), .bits_o(mon_bits),
		.sin_seen_o(mon_sin_seen), .pclk_seen_o(mon_pclk_seen),
		.pclk_cycles_o(mon_pclk_cycles), .ramp_cycles_o(mon_ramp_cycles),
		.gate_cycles_o(mon_gate_cycles), .readouts_o(mon_readouts), .events_o(mon_events)
	);

	completion_responder u_completion_responder (
		.clk_i(clk), .rst_n_i(rst_n),
		.readout_i(readout), .delay_i(resp_delay), .complete_o(complete)
	);

	////////////////////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////////////////////

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_step();
		logic out;
		out = lfsr_q[0];
		lfsr_q = {1'b0, lfsr_q[31:1]} ^ (out ? 32'h80200003 : 32'h0);
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], lfsr_step()};
		return r;
	endfunction

	function automatic logic [31:0] expected_readback(input logic [BUS_ADR_W-1:0] adr);
		logic [31:0] w;
		w = '0;
		case (adr)
			ADDR_CONTROL: begin
				w[1]  = sh_runmode;
				w[16] = sh_regclr;
			end
			ADDR_SHIFT_PRESCALE: w[7:0] = sh_prescale;
			ADDR_RAMP_DELAY:     w[15:0] = sh_delay;
			ADDR_WCLK_STOP:      w[15:0] = sh_stop;
			ADDR_USER_WRITE: begin
				w[28:24] = sh_sel;
				w[23:0]  = sh_word;
			end
			ADDR_TRIGGER:        w[15:8] = sh_count;
			default: ;
		endcase
		return w;
	endfunction

	// bits in the order the chip sees them with the MSB first
	function automatic logic [23:0] expected_stream(input logic [23:0] word);
		logic [23:0] s;
		s = '0;
		for (int i = 23; i >= 0; i--)
			s = {s[22:0], word[i]};
		return s;
	endfunction

	function automatic logic [NUM_LABS-1:0] expected_line(input logic [1:0] chip);
		return NUM_LABS'(1) << chip;
	endfunction

	function automatic int ramp_high_time(input int d, input int s);
		return d + s;
	endfunction

	function automatic int gate_high_time(input int s);
		return s;
	endfunction

	function automatic int readout_total(input int n);
		return n + 1;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (resp_en)
			resp_delay <= 4'(rand_bits(4));
	end

	always @(posedge clk) begin
		while (act_q.size() > 0) begin
			cmp_name = name_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_act  = act_q.pop_front();
			assert (cmp_act === cmp_exp) else begin
				err_count++;
				$display("ERROR %s: expected 0x%08h, actual 0x%08h", cmp_name, cmp_exp, cmp_act);
				$display("Testbench failed");
				$fatal(1, "check failed");
			end
		end
	end

	task automatic post_result(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("Testbench failed");
		$fatal(1, "timeout");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus and pin helpers called on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic bus_access(input logic we, input logic [BUS_ADR_W-1:0] adr,
			input logic [3:0] sel, input logic [31:0] dat, output logic [31:0] rdat);
		int   i;
		logic got;
		bus_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
		@(negedge clk);
		bus_req = '0;
		got = 1'b0;
		for (i = 0; i < BUS_TIMEOUT && !got; i++) begin
			if (bus_rsp.ack)
				got = 1'b1;
			else
				@(negedge clk);
		end
		if (!got)
			timeout_fail("the bus acknowledge");
		rdat = bus_rsp.dat;
	endtask

	task automatic reg_read(input logic [BUS_ADR_W-1:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, 4'hf, 32'h0, rdat);
	endtask

	task automatic reg_write(input logic [BUS_ADR_W-1:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		logic [31:0] echo;
		bus_access(1'b1, adr, sel, dat, echo);
		case (adr)
			ADDR_CONTROL: begin
				sh_runmode = dat[1];
				sh_regclr  = dat[16];
			end
			ADDR_SHIFT_PRESCALE: sh_prescale = dat[7:0];
			ADDR_RAMP_DELAY:     sh_delay = dat[15:0];
			ADDR_WCLK_STOP:      sh_stop = dat[15:0];
			ADDR_USER_WRITE: begin
				sh_sel  = dat[28:24];
				sh_word = dat[23:0];
			end
			ADDR_TRIGGER: if (sel[1])
				sh_count = dat[15:8];
			default: ;
		endcase
	endtask

	task automatic check_all_regs(input string tag);
		logic [31:0] rd;
		foreach (reg_addrs[k]) begin
			reg_read(reg_addrs[k], rd);
			post_result($sformatf("%s_%02h", tag, reg_addrs[k]),
				expected_readback(reg_addrs[k]), rd);
		end
	endtask

	// polls until the status bit reads 0 and can match pending against RAMP
	task automatic poll_until_clear(input logic [BUS_ADR_W-1:0] adr, input int bit_idx,
			input logic track_ramp, input string what, output logic [31:0] rd);
		int   i;
		logic done;
		logic ramp_level;
		done = 1'b0;
		for (i = 0; i < POLL_MAX && !done; i++) begin
			ramp_level = ramp;
			reg_read(adr, rd);
			if (track_ramp)
				post_result("pending_follows_ramp", 32'(ramp_level), 32'(rd[7]));
			done = !rd[bit_idx];
		end
		if (!done)
			timeout_fail(what);
	endtask

	task automatic clear_monitor();
		mon_clear = 1'b1;
		@(negedge clk);
		mon_clear = 1'b0;
	endtask

	task automatic drain_results();
		int i;
		for (i = 0; i < DRAIN_MAX && act_q.size() != 0; i++)
			@(negedge clk);
		if (act_q.size() != 0)
			timeout_fail("the compare process to finish");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] rd;
		logic [31:0] data;
		logic [3:0]  bsel;
		logic [4:0]  sel5;
		logic [23:0] word1;
		logic [1:0]  p;
		logic [1:0]  sel1;
		logic [5:0]  d;
		logic [5:0]  s;
		logic [2:0]  n;
		int          iter;

		rst_n       = 1'b0;
		bus_req     = '0;
		mon_clear   = 1'b0;
		resp_en     = 1'b0;
		resp_delay  = '0;
		err_count   = 0;
		sh_runmode  = 1'b0;
		sh_regclr   = 1'b0;
		sh_prescale = 8'd1;
		sh_delay    = 16'd0;
		sh_stop     = 16'd1024;
		sh_sel      = '0;
		sh_word     = '0;
		sh_count    = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// reset state of pins and registers
		post_result("pins_after_reset", 32'h0, 32'({bus_rsp.ack, sclk, sin, pclk, ramp,
			wclk_gate, readout, event_done, runmode, regclear}));
		check_all_regs("reset");

		// random configuration with the command bits kept clear
		reg_write(ADDR_CONTROL, 4'hf, rand_bits(32));
		reg_write(ADDR_SHIFT_PRESCALE, 4'hf, rand_bits(32));
		reg_write(ADDR_RAMP_DELAY, 4'hf, rand_bits(32));
		reg_write(ADDR_WCLK_STOP, 4'hf, rand_bits(32));
		sel5  = 5'(rand_bits(5));
		word1 = 24'(rand_bits(24));
		reg_write(ADDR_USER_WRITE, 4'hf, {3'b0, sel5, word1});
		bsel = 4'(rand_bits(4));
		data = rand_bits(32) & ~32'h2;
		reg_write(ADDR_TRIGGER, bsel, data);
		check_all_regs("random");
		post_result("runmode_pin", 32'(sh_runmode), 32'(runmode));
		post_result("regclear_pin", 32'(sh_regclr), 32'(regclear));

		// serial loads with a locked-out second write each
		for (iter = 0; iter < 3; iter++) begin
			p     = 2'(rand_bits(2));
			sel1  = 2'(rand_bits(2));
			word1 = 24'(rand_bits(24));
			reg_write(ADDR_SHIFT_PRESCALE, 4'hf, 32'(p));
			clear_monitor();
			reg_write(ADDR_USER_WRITE, 4'hf, {1'b1, 5'b0, sel1, word1});
			@(negedge clk);
			reg_read(ADDR_USER_WRITE, rd);
			post_result("busy_during_load", 32'd1, 32'(rd[31]));
			reg_write(ADDR_USER_WRITE, 4'hf, {1'b1, 5'b0, sel1 ^ 2'b01, ~word1});
			poll_until_clear(ADDR_USER_WRITE, 31, 1'b0, "the serial load", rd);
			post_result("user_write_after_load", expected_readback(ADDR_USER_WRITE), rd);
			post_result("serial_word", 32'(expected_stream(word1)), 32'(mon_word));
			post_result("serial_bits", 32'd24, mon_bits);
			post_result("pclk_line", 32'(expected_line(sel1)), 32'(mon_pclk_seen));
			post_result("sin_other_lines", 32'h0, 32'(mon_sin_seen & ~expected_line(sel1)));
			post_result("pclk_width", 32'(p) + 32'd1, mon_pclk_cycles);
		end

		// ramp and wilkinson gate
		for (iter = 0; iter < 3; iter++) begin
			d = 6'(rand_bits(6));
			s = 6'(rand_bits(6));
			reg_write(ADDR_RAMP_DELAY, 4'hf, 32'(d));
			reg_write(ADDR_WCLK_STOP, 4'hf, 32'(s));
			clear_monitor();
			reg_write(ADDR_RAMP_CMD, 4'hf, 32'h40);
			@(negedge clk);
			poll_until_clear(ADDR_RAMP_CMD, 7, 1'b1, "the ramp to finish", rd);
			post_result("ramp_cycles", ramp_high_time(d, s), mon_ramp_cycles);
			post_result("gate_cycles", gate_high_time(s), mon_gate_cycles);
		end

		// forced readouts with random completion delays
		for (iter = 0; iter < 3; iter++) begin
			n = 3'(rand_bits(3));
			resp_en = 1'b1;
			clear_monitor();
			reg_write(ADDR_TRIGGER, 4'b0011, {16'h0, 5'b0, n, 8'h02});
			@(negedge clk);
			poll_until_clear(ADDR_READOUT, 5, 1'b0, "force_active to clear", rd);
			resp_en = 1'b0;
			post_result("readout_not_done", 32'h0, 32'(rd[0]));
			post_result("readout_pulses", readout_total(n), mon_readouts);
			post_result("event_done_pulses", readout_total(n), mon_events);
		end

		drain_results();
		if (err_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/tb_lab4_ctrl_models.sv */
`timescale 1ns/1ps
`default_nettype none

module pin_monitor #(
	parameter int NUM_LABS = 4
) (
	input  logic                clk_i,
	input  logic                clear_i,
	input  logic [NUM_LABS-1:0] sin_i,
	input  logic                sclk_i,
	input  logic [NUM_LABS-1:0] pclk_i,
	input  logic                ramp_i,
	input  logic                wclk_gate_i,
	input  logic                readout_i,
	input  logic                event_done_i,
	output logic [23:0]         word_o,
	output int                  bits_o,
	output logic [NUM_LABS-1:0] sin_seen_o,
	output logic [NUM_LABS-1:0] pclk_seen_o,
	output int                  pclk_cycles_o,
	output int                  ramp_cycles_o,
	output int                  gate_cycles_o,
	output int                  readouts_o,
	output int                  events_o
);
	logic sclk_q;

	// every counter sees the pins as they were during the cycle just ended
	always @(posedge clk_i) begin
		if (clear_i) begin
			sclk_q        <= 1'b0;
			word_o        <= '0;
			bits_o        <= 0;
			sin_seen_o    <= '0;
			pclk_seen_o   <= '0;
			pclk_cycles_o <= 0;
			ramp_cycles_o <= 0;
			gate_cycles_o <= 0;
			readouts_o    <= 0;
			events_o      <= 0;
		end else begin
			sclk_q <= sclk_i;
			// chip samples SIN on the rising SCLK
			if (sclk_i && !sclk_q) begin
				word_o <= {word_o[22:0], |sin_i};
				bits_o <= bits_o + 1;
			end
			sin_seen_o    <= sin_seen_o | sin_i;
			pclk_seen_o   <= pclk_seen_o | pclk_i;
			pclk_cycles_o <= pclk_cycles_o + int'(|pclk_i);
			ramp_cycles_o <= ramp_cycles_o + int'(ramp_i);
			gate_cycles_o <= gate_cycles_o + int'(wclk_gate_i);
			readouts_o    <= readouts_o + int'(readout_i);
			events_o      <= events_o + int'(event_done_i);
		end
	end

endmodule

module completion_responder (
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       readout_i,
	input  logic [3:0] delay_i,
	output logic       complete_o
);
	logic       waiting;
	logic [3:0] wait_cnt;

	initial complete_o = 1'b0;

	// answers on the falling edge, delay_i cycles after the readout pulse
	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			waiting  = 1'b0;
			wait_cnt = '0;
			complete_o <= 1'b0;
		end else begin
			complete_o <= 1'b0;
			if (readout_i) begin
				waiting  = 1'b1;
				wait_cnt = delay_i;
			end
			if (waiting) begin
				if (wait_cnt == 4'd0) begin
					waiting = 1'b0;
					complete_o <= 1'b1;
				end else begin
					wait_cnt = wait_cnt - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire
